/* tile_bus_pkg.sv */
/* Single-transfer bus types and the tile address map. No burst, retry or cab
   signals; SRAM sits below 0x8000_0000 and regions 8 to D are unmapped */
package tile_bus_pkg;

   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [31:0] adr;
      logic [31:0] dat;
      logic [3:0]  sel;
   } wb_req_t;

   typedef struct packed {
      logic        ack;
      logic        err;
      logic [31:0] dat;
   } wb_rsp_t;

   typedef enum logic [1:0] {
      SLV_MEM,
      SLV_NA,
      SLV_ROM,
      SLV_NONE
   } slave_e;

   localparam logic [3:0] NA_REGION  = 4'he;   // Match on adr[31:28]
   localparam logic [3:0] ROM_REGION = 4'hf;

   // Small loader that jumps to SRAM offset 0x100
   localparam logic [0:7][31:0] BOOT_WORDS = {
      32'h1820_0000, 32'ha821_0000, 32'h1860_0000, 32'ha863_0100,
      32'h4400_1800, 32'h1500_0000, 32'h1500_0001, 32'h0000_0000
   };

endpackage

/* tile_noc_pkg.sv */
/* NoC flit format and adapter register map. One virtual channel only,
   adapter registers are full 32-bit words selected by adr[3:2] */
package tile_noc_pkg;

   localparam int FLIT_DATA_WIDTH = 32;

   typedef enum logic [1:0] {
      FLIT_PAYLOAD = 2'b00,
      FLIT_HEAD    = 2'b01,
      FLIT_TAIL    = 2'b10,
      FLIT_SINGLE  = 2'b11   // Head and tail in one
   } flit_type_e;

   typedef struct packed {
      flit_type_e                 ftype;
      logic [FLIT_DATA_WIDTH-1:0] data;
   } noc_flit_t;

   typedef enum logic [1:0] {
      REG_SEND   = 2'd0,
      REG_RECV   = 2'd1,
      REG_STATUS = 2'd2
   } na_reg_e;

endpackage

/* wb_arbiter.sv */
/* Round-robin arbiter for single transfers. A grant lasts while the holder keeps
   cyc high, so a master must drop cyc after each ack or err to let others in */
`timescale 1ns/1ns

module wb_arbiter #(
   parameter int MASTERS = 3
) (
   input  logic                                clk,
   input  logic                                arst_n_i,
   input  tile_bus_pkg::wb_req_t [MASTERS-1:0] m_req_i,
   output tile_bus_pkg::wb_rsp_t [MASTERS-1:0] m_rsp_o,
   output tile_bus_pkg::wb_req_t               s_req_o,
   input  tile_bus_pkg::wb_rsp_t               s_rsp_i
);

   localparam int IDX_W = (MASTERS > 1) ? $clog2(MASTERS) : 1;

   logic [MASTERS-1:0] grant_q;      // One-hot, zero while bus is free
   logic [MASTERS-1:0] grant_d;
   logic [IDX_W-1:0]   last_q;       // Current or most recent holder
   logic [IDX_W-1:0]   last_d;
   logic               grant_valid;
   logic               holder_busy;

   assign grant_valid = |grant_q;
   assign holder_busy = grant_valid & m_req_i[last_q].cyc;

   // Search starts one past the last holder
   always_comb begin
      int   idx;
      logic found;
      grant_d = grant_q;
      last_d  = last_q;
      found   = 1'b0;
      idx     = 0;
      if (!holder_busy) begin
         grant_d = '0;
         for (int off = 1; off <= MASTERS; off++) begin
            idx = (int'(last_q) + off) % MASTERS;
            if (!found && m_req_i[idx].cyc) begin
               found        = 1'b1;
               grant_d[idx] = 1'b1;
               last_d       = IDX_W'(idx);
            end
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         grant_q <= '0;
         last_q  <= IDX_W'(MASTERS - 1);   // Master 0 wins first
      end else begin
         grant_q <= grant_d;
         last_q  <= last_d;
      end
   end

   always_comb begin
      s_req_o = '0;                        // Idle request when nobody holds
      if (grant_valid)
         s_req_o = m_req_i[last_q];
      for (int i = 0; i < MASTERS; i++)
         m_rsp_o[i] = grant_q[i] ? s_rsp_i : '0;
   end

   a_grant_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
      $onehot0(grant_q));

endmodule

/* wb_decoder.sv */
/* Address decoder for three slaves. Unmapped accesses get a registered err
   one cycle after stb; the address must stay stable until the answer */
`timescale 1ns/1ns

module wb_decoder (
   input  logic                  clk,
   input  logic                  arst_n_i,
   input  tile_bus_pkg::wb_req_t req_i,
   output tile_bus_pkg::wb_req_t mem_req_o,
   output tile_bus_pkg::wb_req_t na_req_o,
   output tile_bus_pkg::wb_req_t rom_req_o,
   input  tile_bus_pkg::wb_rsp_t mem_rsp_i,
   input  tile_bus_pkg::wb_rsp_t na_rsp_i,
   input  tile_bus_pkg::wb_rsp_t rom_rsp_i,
   output tile_bus_pkg::wb_rsp_t rsp_o
);

   import tile_bus_pkg::*;

   slave_e slave;
   logic   none_err_q;   // Answer for unmapped regions

   // Other slaves see the address and data but no strobe
   function automatic wb_req_t gate_req(input wb_req_t req, input logic en);
      wb_req_t g;
      g     = req;
      g.cyc = req.cyc & en;
      g.stb = req.stb & en;
      return g;
   endfunction

   always_comb begin
      if (!req_i.adr[31])
         slave = SLV_MEM;
      else if (req_i.adr[31:28] == NA_REGION)
         slave = SLV_NA;
      else if (req_i.adr[31:28] == ROM_REGION)
         slave = SLV_ROM;
      else
         slave = SLV_NONE;                  // Regions 8 to D
   end

   assign mem_req_o = gate_req(req_i, slave == SLV_MEM);
   assign na_req_o  = gate_req(req_i, slave == SLV_NA);
   assign rom_req_o = gate_req(req_i, slave == SLV_ROM);

   always_comb begin
      case (slave)
         SLV_MEM: rsp_o = mem_rsp_i;
         SLV_NA:  rsp_o = na_rsp_i;
         SLV_ROM: rsp_o = rom_rsp_i;
         default: rsp_o = '{ack: 1'b0, err: none_err_q, dat: 32'h0};
      endcase
   end

   // Skip the cycle after an err, stb is still high from the master then
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i)
         none_err_q <= 1'b0;
      else
         none_err_q <= req_i.cyc & req_i.stb & (slave == SLV_NONE) & ~none_err_q;
   end

endmodule

/* wb_sram.sv */
/* Word SRAM with no initial contents. The index wraps at MEM_WORDS, sel picks
   the bytes to write, and err is never raised */
`timescale 1ns/1ns

module wb_sram #(
   parameter int MEM_WORDS = 256
) (
   input  logic                  clk,
   input  logic                  arst_n_i,
   input  tile_bus_pkg::wb_req_t req_i,
   output tile_bus_pkg::wb_rsp_t rsp_o
);

   localparam int AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

   logic [31:0]   mem [MEM_WORDS];
   logic [AW-1:0] word_idx;
   logic          access;
   logic          ack_q;
   logic [31:0]   dat_q;

   assign word_idx = AW'(req_i.adr[31:2] % MEM_WORDS);
   assign access   = req_i.cyc & req_i.stb & ~ack_q;   // Master still holds stb after ack

   always_ff @(posedge clk) begin
      if (access) begin
         if (req_i.we) begin
            for (int b = 0; b < 4; b++) begin
               if (req_i.sel[b])
                  mem[word_idx][8*b +: 8] <= req_i.dat[8*b +: 8];
            end
         end else begin
            dat_q <= mem[word_idx];
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i)
         ack_q <= 1'b0;
      else
         ack_q <= access;
   end

   assign rsp_o = '{ack: ack_q, err: 1'b0, dat: dat_q};

   a_ack_gap: assert property (@(posedge clk) disable iff (!arst_n_i)
      ack_q |=> !ack_q);

endmodule

/* bootrom.sv */
/* Eight-word boot ROM, mirrored over its whole region by adr[4:2].
   Writes are answered with err and change nothing */
`timescale 1ns/1ns

module bootrom (
   input  logic                  clk,
   input  logic                  arst_n_i,
   input  tile_bus_pkg::wb_req_t req_i,
   output tile_bus_pkg::wb_rsp_t rsp_o
);

   import tile_bus_pkg::*;

   logic        access;
   logic        ack_q;
   logic        err_q;
   logic [31:0] dat_q;

   assign access = req_i.cyc & req_i.stb & ~(ack_q | err_q);

   always_ff @(posedge clk) begin
      if (access)
         dat_q <= BOOT_WORDS[req_i.adr[4:2]];
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= access & ~req_i.we;
         err_q <= access & req_i.we;    // Read-only
      end
   end

   assign rsp_o = '{ack: ack_q, err: err_q, dat: dat_q};

endmodule

/* mp_simple_na.sv */
/* Simple message passing with one send flit and one receive flit buffered.
   A send write stalls the whole bus until the previous flit leaves; sel is ignored */
`timescale 1ns/1ns

module mp_simple_na (
   input  logic                    clk,
   input  logic                    arst_n_i,
   input  tile_bus_pkg::wb_req_t   req_i,
   output tile_bus_pkg::wb_rsp_t   rsp_o,
   input  tile_noc_pkg::noc_flit_t noc_in_flit_i,
   input  logic                    noc_in_valid_i,
   output logic                    noc_in_ready_o,
   output tile_noc_pkg::noc_flit_t noc_out_flit_o,
   output logic                    noc_out_valid_o,
   input  logic                    noc_out_ready_i,
   output logic                    irq_o
);

   import tile_noc_pkg::*;

   typedef enum logic {
      IDLE,
      SEND_WAIT
   } send_state_e;

   send_state_e state_q;
   noc_flit_t   out_flit_q;
   noc_flit_t   rx_flit_q;
   logic        rx_full_q;
   na_reg_e     reg_sel;
   logic        bus_req;
   logic        send_load;
   logic        recv_pop;
   logic        ack_d;
   logic        err_d;
   logic        ack_q;
   logic        err_q;
   logic [31:0] dat_d;
   logic [31:0] dat_q;

   assign bus_req = req_i.cyc & req_i.stb & ~(ack_q | err_q);
   assign reg_sel = na_reg_e'(req_i.adr[3:2]);

   always_comb begin
      ack_d     = 1'b0;
      err_d     = 1'b0;
      dat_d     = '0;
      send_load = 1'b0;
      recv_pop  = 1'b0;
      if (bus_req) begin
         case (reg_sel)
            REG_SEND: begin
               if (!req_i.we) begin
                  err_d = 1'b1;
               end else if (state_q == IDLE) begin
                  ack_d     = 1'b1;       // Otherwise wait, no answer yet
                  send_load = 1'b1;
               end
            end
            REG_RECV: begin
               if (req_i.we || !rx_full_q) begin
                  err_d = 1'b1;
               end else begin
                  ack_d    = 1'b1;
                  dat_d    = rx_flit_q.data;
                  recv_pop = 1'b1;
               end
            end
            REG_STATUS: begin
               if (req_i.we) begin
                  err_d = 1'b1;
               end else begin
                  ack_d = 1'b1;
                  dat_d = {28'h0, rx_full_q ? rx_flit_q.ftype : FLIT_PAYLOAD,
                           state_q == SEND_WAIT, rx_full_q};
               end
            end
            default: err_d = 1'b1;        // adr[3:2] == 3
         endcase
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q   <= IDLE;
         rx_full_q <= 1'b0;
         ack_q     <= 1'b0;
         err_q     <= 1'b0;
      end else begin
         ack_q <= ack_d;
         err_q <= err_d;
         case (state_q)
            IDLE:      if (send_load) state_q <= SEND_WAIT;
            SEND_WAIT: if (noc_out_ready_i) state_q <= IDLE;
            default:   state_q <= IDLE;
         endcase
         if (recv_pop)
            rx_full_q <= 1'b0;
         else if (noc_in_valid_i)
            rx_full_q <= 1'b1;           // Sticks until read
      end
   end

   always_ff @(posedge clk) begin
      if (send_load)
         out_flit_q <= '{ftype: FLIT_SINGLE, data: req_i.dat};
      if (noc_in_valid_i && !rx_full_q)
         rx_flit_q <= noc_in_flit_i;
      if (bus_req)
         dat_q <= dat_d;
   end

   assign noc_out_flit_o  = out_flit_q;
   assign noc_out_valid_o = (state_q == SEND_WAIT);
   assign noc_in_ready_o  = ~rx_full_q;
   assign irq_o           = rx_full_q;     // Level while a flit waits
   assign rsp_o           = '{ack: ack_q, err: err_q, dat: dat_q};

   a_out_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
      noc_out_valid_o && !noc_out_ready_i |=> noc_out_valid_o && $stable(noc_out_flit_o));

endmodule

/* compute_tile.sv */
/* Compute tile without cores, its masters come from outside. SRAM below 0x8000_0000,
   adapter at region E, boot ROM at F; regions 8 to D answer with err */
`timescale 1ns/1ns

module compute_tile #(
   parameter int MASTERS   = 3,
   parameter int MEM_WORDS = 256
) (
   input  logic                                clk,
   input  logic                                arst_n_i,
   input  tile_bus_pkg::wb_req_t [MASTERS-1:0] m_req_i,
   output tile_bus_pkg::wb_rsp_t [MASTERS-1:0] m_rsp_o,
   input  tile_noc_pkg::noc_flit_t             noc_in_flit_i,
   input  logic                                noc_in_valid_i,
   output logic                                noc_in_ready_o,
   output tile_noc_pkg::noc_flit_t             noc_out_flit_o,
   output logic                                noc_out_valid_o,
   input  logic                                noc_out_ready_i,
   output logic                                irq_o
);

   import tile_bus_pkg::*;

   wb_req_t bus_req;     // Granted master
   wb_rsp_t bus_rsp;
   wb_req_t mem_req;
   wb_rsp_t mem_rsp;
   wb_req_t na_req;
   wb_rsp_t na_rsp;
   wb_req_t rom_req;
   wb_rsp_t rom_rsp;

   wb_arbiter #(
      .MASTERS (MASTERS)
   ) u_arbiter (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .m_req_i  (m_req_i),
      .m_rsp_o  (m_rsp_o),
      .s_req_o  (bus_req),
      .s_rsp_i  (bus_rsp)
   );

   wb_decoder u_decoder (
      .clk       (clk),
      .arst_n_i  (arst_n_i),
      .req_i     (bus_req),
      .mem_req_o (mem_req),
      .na_req_o  (na_req),
      .rom_req_o (rom_req),
      .mem_rsp_i (mem_rsp),
      .na_rsp_i  (na_rsp),
      .rom_rsp_i (rom_rsp),
      .rsp_o     (bus_rsp)
   );

   wb_sram #(
      .MEM_WORDS (MEM_WORDS)
   ) u_sram (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .req_i    (mem_req),
      .rsp_o    (mem_rsp)
   );

   bootrom u_bootrom (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .req_i    (rom_req),
      .rsp_o    (rom_rsp)
   );

   mp_simple_na u_na (
      .clk             (clk),
      .arst_n_i        (arst_n_i),
      .req_i           (na_req),
      .rsp_o           (na_rsp),
      .noc_in_flit_i   (noc_in_flit_i),
      .noc_in_valid_i  (noc_in_valid_i),
      .noc_in_ready_o  (noc_in_ready_o),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i),
      .irq_o           (irq_o)
   );

endmodule

/* tb_compute_tile.sv */
/* Random traffic from three masters against a shadow model of SRAM, boot ROM and NoC.
   Stops at the first mismatch; a watchdog bounds the run */
`timescale 1ns/1ns

module tb_compute_tile;

   import tile_bus_pkg::*;
   import tile_noc_pkg::*;

   localparam int MASTERS     = 3;
   localparam int MEM_WORDS   = 256;
   localparam int AW          = $clog2(MEM_WORDS);
   localparam int CLK_PERIOD  = 100;
   localparam int N_MEM       = 60;    // Per master
   localparam int N_SEND      = 20;
   localparam int N_RECV      = 10;
   localparam int TOTAL_XFERS = MASTERS * N_MEM + N_SEND + 4 * N_RECV;
   localparam logic [31:0] NA_SEND   = {NA_REGION, 28'h000_0000};
   localparam logic [31:0] NA_RECV   = {NA_REGION, 28'h000_0004};
   localparam logic [31:0] NA_STATUS = {NA_REGION, 28'h000_0008};

   logic                  clk             = 1'b0;
   logic                  arst_n          = 1'b0;
   wb_req_t [MASTERS-1:0] m_req           = '0;
   wb_rsp_t [MASTERS-1:0] m_rsp;
   noc_flit_t             noc_in_flit_i   = '0;
   logic                  noc_in_valid_i  = 1'b0;
   logic                  noc_in_ready_o;
   noc_flit_t             noc_out_flit_o;
   logic                  noc_out_valid_o;
   logic                  noc_out_ready_i = 1'b0;
   logic                  irq_o;

   int          seed = 32'h547a;
   int          rdy_seed;
   logic [31:0] shadow [MEM_WORDS];
   logic [3:0]  written [MEM_WORDS];   // Bytes holding known data
   logic [31:0] sent_q[$];
   noc_flit_t   recv_q[$];

   compute_tile #(
      .MASTERS   (MASTERS),
      .MEM_WORDS (MEM_WORDS)
   ) dut (
      .clk             (clk),
      .arst_n_i        (arst_n),
      .m_req_i         (m_req),
      .m_rsp_o         (m_rsp),
      .noc_in_flit_i   (noc_in_flit_i),
      .noc_in_valid_i  (noc_in_valid_i),
      .noc_in_ready_o  (noc_in_ready_o),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i),
      .irq_o           (irq_o)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("error: %s is %h, expected %h", name, got, exp);
         $display("Checks failed");
         $fatal(1);
      end
   endtask

   function automatic logic [31:0] byte_mask(input logic [3:0] sel);
      return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
   endfunction

   // One single transfer, cyc dropped in the cycle after the answer
   task automatic bus_transfer(input int m, input logic we, input logic [31:0] adr,
                               input logic [31:0] wdat, input logic [3:0] sel,
                               output wb_rsp_t rsp);
      @(posedge clk);
      m_req[m] <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat, sel: sel};
      do
         @(negedge clk);
      while (!(m_rsp[m].ack || m_rsp[m].err));
      rsp = m_rsp[m];
      @(posedge clk);
      m_req[m] <= '0;
   endtask

   task automatic expect_answer(input wb_rsp_t rsp, input logic ack);
      compare("m_rsp_o.ack", 32'(rsp.ack), 32'(ack));
      compare("m_rsp_o.err", 32'(rsp.err), 32'(!ack));
   endtask

   // Master m owns the SRAM words whose index modulo 3 is m
   task automatic master_traffic(input int m);
      int          s;
      logic [31:0] r;
      logic [31:0] hi;
      logic [31:0] wdat;
      logic [31:0] adr;
      logic [7:0]  w;
      logic [AW-1:0] idx;
      wb_rsp_t     rsp;
      s = seed + 1000 * m;
      for (int n = 0; n < N_MEM; n++) begin
         r    = $random(s);
         hi   = $random(s);
         wdat = $random(s);
         if (r % 16 < 10) begin
            w   = 8'(3 * ((r >> 12) % (MEM_WORDS / 3)) + m);
            adr = {1'b0, hi[20:0], w, 2'b00};   // Upper bits wrap away
            idx = AW'(adr[31:2] % MEM_WORDS);
            bus_transfer(m, r[4], adr, wdat, r[11:8], rsp);
            expect_answer(rsp, 1'b1);
            if (r[4]) begin
               shadow[idx]  = (shadow[idx] & ~byte_mask(r[11:8])) |
                              (wdat & byte_mask(r[11:8]));
               written[idx] = written[idx] | r[11:8];
            end else begin
               compare("m_rsp_o.dat", rsp.dat & byte_mask(written[idx]),
                       shadow[idx] & byte_mask(written[idx]));
            end
         end else if (r % 16 < 13) begin
            adr = {ROM_REGION, hi[27:0]};
            bus_transfer(m, r[4], adr, wdat, 4'hf, rsp);
            expect_answer(rsp, !r[4]);        // Writes must fail
            if (!r[4])
               compare("m_rsp_o.dat", rsp.dat, BOOT_WORDS[adr[4:2]]);
         end else begin
            adr = {4'(8 + (r >> 20) % 6), hi[27:0]};
            bus_transfer(m, r[4], adr, wdat, 4'hf, rsp);
            expect_answer(rsp, 1'b0);
         end
      end
   endtask

   task automatic offer_flit(input noc_flit_t f);
      @(posedge clk);
      noc_in_flit_i  <= f;
      noc_in_valid_i <= 1'b1;
      do
         @(negedge clk);
      while (!noc_in_ready_o);
      @(posedge clk);                      // Flit taken on this edge
      noc_in_valid_i <= 1'b0;
      recv_q.push_back(f);
   endtask

   always @(posedge clk) begin : ready_toggle
      logic [31:0] r;
      r = $random(rdy_seed);
      noc_out_ready_i <= r[0];
   end

   always @(negedge clk) begin
      if (arst_n && noc_out_valid_o && noc_out_ready_i) begin
         if (sent_q.size() == 0) begin
            $display("A flit left on the NoC output that was never written");
            $display("Checks failed");
            $fatal(1);
         end else begin
            compare("noc_out_flit_o.data", noc_out_flit_o.data, sent_q.pop_front());
            compare("noc_out_flit_o.ftype", 32'(noc_out_flit_o.ftype), 32'(FLIT_SINGLE));
         end
      end
   end

   initial begin
      #(CLK_PERIOD * 40 * TOTAL_XFERS);
      $display("Timeout, the tests did not complete in time");
      $display("Checks failed");
      $fatal(1);
   end

   initial begin
      wb_rsp_t     rsp;
      noc_flit_t   f;
      logic [31:0] r;
      rdy_seed = seed + 1;
      foreach (written[i])
         written[i] = 4'h0;
      repeat (5) @(posedge clk);
      arst_n <= 1'b1;

      fork
         master_traffic(0);
         master_traffic(1);
         master_traffic(2);
      join

      for (int n = 0; n < N_SEND; n++) begin
         r = $random(seed);
         sent_q.push_back(r);
         bus_transfer(0, 1'b1, NA_SEND, r, 4'hf, rsp);
         expect_answer(rsp, 1'b1);
      end
      while (sent_q.size() != 0)
         @(negedge clk);

      for (int n = 0; n < N_RECV; n++) begin
         bus_transfer(0, 1'b0, NA_RECV, 32'h0, 4'hf, rsp);
         expect_answer(rsp, 1'b0);            // Buffer still empty
         r = $random(seed);
         f = '{ftype: flit_type_e'(r[1:0]), data: $random(seed)};
         offer_flit(f);
         @(negedge clk);
         compare("irq_o", 32'(irq_o), 32'd1);
         compare("noc_in_ready_o", 32'(noc_in_ready_o), 32'd0);
         bus_transfer(0, 1'b0, NA_STATUS, 32'h0, 4'hf, rsp);
         expect_answer(rsp, 1'b1);
         compare("m_rsp_o.dat", rsp.dat, {28'h0, recv_q[0].ftype, 1'b0, 1'b1});
         bus_transfer(0, 1'b0, NA_RECV, 32'h0, 4'hf, rsp);
         expect_answer(rsp, 1'b1);
         compare("m_rsp_o.dat", rsp.dat, recv_q.pop_front().data);
         @(negedge clk);
         compare("irq_o", 32'(irq_o), 32'd0);
         compare("noc_in_ready_o", 32'(noc_in_ready_o), 32'd1);
      end

      $display("All checks passed");
      $finish;
   end

endmodule

/* build.f */
tile_bus_pkg.sv
tile_noc_pkg.sv
wb_arbiter.sv
wb_decoder.sv
wb_sram.sv
bootrom.sv
mp_simple_na.sv
compute_tile.sv
tb_compute_tile.sv

/* run.sh */
#!/bin/sh
# Builds the tile and its testbench with Verilator, runs it and looks for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_compute_tile
out=$(./obj_dir/Vtb_compute_tile 2>&1 || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "All checks passed"
